//--- cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Number of architectural registers in the register file.
`define CPU_NREGS 16

// Width of a register and of the ALU datapath.
`define CPU_XLEN 32

// Width of the immediate field in the instruction word.
`define CPU_IMM_W 16

`endif

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_addr_t;
	typedef logic [`CPU_XLEN-1:0] word_t;

	// Codes 9 to 14 are unused and execute as NOP.
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		SHL  = 4'd6,
		ADDI = 4'd7,
		LDI  = 4'd8,
		HALT = 4'd15
	} op_e;

	typedef struct packed {
		logic [3:0]            opcode;
		reg_addr_t             rd;
		reg_addr_t             ra;
		reg_addr_t             rb;
		logic [`CPU_IMM_W-1:0] imm;
	} ins_t;

	typedef struct packed {
		logic      valid;
		op_e       op;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		word_t     a;
		word_t     b;
		word_t     imm;
	} dec_pkt_t;

	// Shared by the execute and result stages.
	typedef struct packed {
		logic      valid;
		logic      wr;
		reg_addr_t rd;
		word_t     data;
		logic      halt;
	} res_pkt_t;

endpackage

`default_nettype wire

//--- cpu_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpu_regfile (
	input  wire logic               clk_i,
	input  wire logic               arst_n_i,
	input  wire cpu_pkg::reg_addr_t rd_addr_a_i,
	input  wire cpu_pkg::reg_addr_t rd_addr_b_i,
	output logic [`CPU_XLEN-1:0]    rd_data_a_o,
	output logic [`CPU_XLEN-1:0]    rd_data_b_o,
	input  wire cpu_pkg::res_pkt_t  wr_i
);

	cpu_pkg::word_t regs [`CPU_NREGS];
	logic           we;

	assign we = wr_i.valid && wr_i.wr;

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int i = 0; i < `CPU_NREGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we)
		begin
			regs[wr_i.rd] <= wr_i.data;
		end
	end

	// A read of the register being written sees the new value in the same cycle.
	always_comb
	begin
		rd_data_a_o = (we && (wr_i.rd == rd_addr_a_i)) ? wr_i.data : regs[rd_addr_a_i];
		rd_data_b_o = (we && (wr_i.rd == rd_addr_b_i)) ? wr_i.data : regs[rd_addr_b_i];
	end

	// The result stage is held in reset together with the register file.
	a_no_write_in_reset : assert property (
		@(posedge clk_i) !arst_n_i |-> !we
	) else $error("register write while in reset");

endmodule

`default_nettype wire

//--- cpu_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpu_decode (
	input  wire logic              clk_i,
	input  wire logic              arst_n_i,
	input  wire logic              ins_valid_i,
	input  wire cpu_pkg::ins_t     ins_i,
	input  wire cpu_pkg::res_pkt_t wb_i,
	output cpu_pkg::dec_pkt_t      dec_o
);

	cpu_pkg::word_t    rf_a;
	cpu_pkg::word_t    rf_b;
	cpu_pkg::op_e      op;
	cpu_pkg::word_t    imm_ext;
	logic              accept;
	logic              halt_q;
	cpu_pkg::dec_pkt_t dec_d;
	cpu_pkg::dec_pkt_t dec_q;

	cpu_regfile u_regfile (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.rd_addr_a_i (ins_i.ra),
		.rd_addr_b_i (ins_i.rb),
		.rd_data_a_o (rf_a),
		.rd_data_b_o (rf_b),
		.wr_i        (wb_i)
	);

	assign op      = cpu_pkg::op_e'(ins_i.opcode);
	assign imm_ext = {{(`CPU_XLEN-`CPU_IMM_W){ins_i.imm[`CPU_IMM_W-1]}}, ins_i.imm};

	// Once a HALT has been taken, the input strobe is ignored until reset.
	assign accept = ins_valid_i && !halt_q;

	always_comb
	begin
		dec_d       = '0;
		dec_d.valid = accept;
		dec_d.op    = op;
		dec_d.rd    = ins_i.rd;
		dec_d.ra    = ins_i.ra;
		dec_d.rb    = ins_i.rb;
		dec_d.a     = rf_a;
		dec_d.b     = rf_b;
		dec_d.imm   = imm_ext;
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			dec_q <= '0;
		end
		else
		begin
			dec_q <= dec_d;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			halt_q <= 1'b0;
		end
		else if (accept && (op == cpu_pkg::HALT))
		begin
			halt_q <= 1'b1;
		end
	end

	assign dec_o = dec_q;

	// The HALT packet itself is the last valid one.
	a_quiet_after_halt : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		halt_q |=> !dec_q.valid
	) else $error("decode packet valid after halt");

endmodule

`default_nettype wire

//--- cpu_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpu_execute (
	input  wire logic              clk_i,
	input  wire logic              arst_n_i,
	input  wire cpu_pkg::dec_pkt_t dec_i,
	input  wire cpu_pkg::res_pkt_t res_i,
	output cpu_pkg::res_pkt_t      exe_o
);

	cpu_pkg::res_pkt_t exe_q;
	cpu_pkg::res_pkt_t exe_d;
	cpu_pkg::word_t    op_a;
	cpu_pkg::word_t    op_b;
	cpu_pkg::word_t    alu_res;
	logic              is_wr;

	// The younger packet wins, then the older one, then the register file.
	function automatic cpu_pkg::word_t fwd_sel(
		input cpu_pkg::reg_addr_t src,
		input cpu_pkg::word_t     rf_val,
		input cpu_pkg::res_pkt_t  near,
		input cpu_pkg::res_pkt_t  far
	);
		cpu_pkg::word_t val;
		if (near.valid && near.wr && (near.rd == src))
		begin
			val = near.data;
		end
		else if (far.valid && far.wr && (far.rd == src))
		begin
			val = far.data;
		end
		else
		begin
			val = rf_val;
		end
		return val;
	endfunction

	assign op_a = fwd_sel(dec_i.ra, dec_i.a, exe_q, res_i);
	assign op_b = fwd_sel(dec_i.rb, dec_i.b, exe_q, res_i);

	always_comb
	begin
		alu_res = '0;
		is_wr   = 1'b1;
		case (dec_i.op)
			cpu_pkg::ADD:  alu_res = op_a + op_b;
			cpu_pkg::SUB:  alu_res = op_a - op_b;
			cpu_pkg::AND:  alu_res = op_a & op_b;
			cpu_pkg::OR:   alu_res = op_a | op_b;
			cpu_pkg::XOR:  alu_res = op_a ^ op_b;
			cpu_pkg::SHL:  alu_res = op_a << op_b[$clog2(`CPU_XLEN)-1:0];
			cpu_pkg::ADDI: alu_res = op_a + dec_i.imm;
			cpu_pkg::LDI:  alu_res = dec_i.imm;
			default:       is_wr   = 1'b0;
		endcase
	end

	always_comb
	begin
		exe_d       = '0;
		exe_d.valid = dec_i.valid;
		exe_d.wr    = dec_i.valid && is_wr;
		exe_d.rd    = dec_i.rd;
		exe_d.data  = alu_res;
		exe_d.halt  = dec_i.valid && (dec_i.op == cpu_pkg::HALT);
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			exe_q <= '0;
		end
		else
		begin
			exe_q <= exe_d;
		end
	end

	assign exe_o = exe_q;

	a_wr_halt_exclusive : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		exe_q.halt |-> !exe_q.wr
	) else $error("execute packet both writes and halts");

endmodule

`default_nettype wire

//--- cpu_result.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_result (
	input  wire logic              clk_i,
	input  wire logic              arst_n_i,
	input  wire cpu_pkg::res_pkt_t exe_i,
	output cpu_pkg::res_pkt_t      res_o,
	output logic                   halted_o
);

	cpu_pkg::res_pkt_t res_q;
	logic              halted_q;

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			res_q <= '0;
		end
		else
		begin
			res_q <= exe_i;
		end
	end

	// The flag rises with the HALT packet and holds until reset.
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			halted_q <= 1'b0;
		end
		else if (exe_i.valid && exe_i.halt)
		begin
			halted_q <= 1'b1;
		end
	end

	assign res_o    = res_q;
	assign halted_o = halted_q;

	// Decode stops taking words at HALT, so nothing may retire behind it.
	a_no_write_after_halt : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		halted_q |-> !(res_q.valid && res_q.wr)
	) else $error("writeback after halt");

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input  wire logic           clk_i,
	input  wire logic           arst_n_i,
	input  wire logic           ins_valid_i,
	input  wire cpu_pkg::ins_t  ins_i,
	output logic                wb_valid_o,
	output cpu_pkg::reg_addr_t  wb_addr_o,
	output cpu_pkg::word_t      wb_data_o,
	output logic                halt_o
);

	cpu_pkg::dec_pkt_t dec_pkt;
	cpu_pkg::res_pkt_t exe_pkt;
	cpu_pkg::res_pkt_t res_pkt;
	logic              halted;

	cpu_decode u_decode (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.ins_valid_i (ins_valid_i),
		.ins_i       (ins_i),
		.wb_i        (res_pkt),
		.dec_o       (dec_pkt)
	);

	cpu_execute u_execute (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.dec_i    (dec_pkt),
		.res_i    (res_pkt),
		.exe_o    (exe_pkt)
	);

	cpu_result u_result (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.exe_i    (exe_pkt),
		.res_o    (res_pkt),
		.halted_o (halted)
	);

	// Only writing instructions pulse the writeback strobe.
	assign wb_valid_o = res_pkt.valid && res_pkt.wr;
	assign wb_addr_o  = res_pkt.rd;
	assign wb_data_o  = res_pkt.data;
	assign halt_o     = halted;

endmodule

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu;

	typedef struct packed {
		logic [3:0]  addr;
		logic [31:0] data;
	} wb_exp_t;

	logic          clk_i;
	logic          arst_n_i;
	logic          ins_valid_i;
	cpu_pkg::ins_t ins_i;
	logic          wb_valid_o;
	logic [3:0]    wb_addr_o;
	logic [31:0]   wb_data_o;
	logic          halt_o;

	integer        seed;
	string         test_name;
	int            errors;
	int            errors_at_start;
	int            tests_passed;
	int            tests_failed;
	logic [31:0]   model_regs [`CPU_NREGS];
	wb_exp_t       exp_q [$];
	wb_exp_t       head;
	logic          head_ok;
	logic          halt_issued;
	logic          issue_wr;
	logic [2:0]    wr_hist;
	logic [2:0]    halt_hist;

	cpu_top u_cpu_top (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.ins_valid_i (ins_valid_i),
		.ins_i       (ins_i),
		.wb_valid_o  (wb_valid_o),
		.wb_addr_o   (wb_addr_o),
		.wb_data_o   (wb_data_o),
		.halt_o      (halt_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	function automatic logic is_writing(input logic [3:0] opc);
		return (opc >= 4'd1) && (opc <= 4'd8);
	endfunction

	// Expected result of a writing instruction.
	function automatic logic [31:0] model_alu(input logic [3:0] opc, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] imm);
		case (opc)
			cpu_pkg::ADD:  return a + b;
			cpu_pkg::SUB:  return a - b;
			cpu_pkg::AND:  return a & b;
			cpu_pkg::OR:   return a | b;
			cpu_pkg::XOR:  return a ^ b;
			cpu_pkg::SHL:  return a << b[4:0];
			cpu_pkg::ADDI: return a + imm;
			cpu_pkg::LDI:  return imm;
			default:       return 32'd0;
		endcase
	endfunction

	// An instruction that the core will accept and that writes a register.
	assign issue_wr = ins_valid_i && is_writing(ins_i.opcode) && !halt_issued;

	// Issue history over the three edges of pipeline latency.
	always @(posedge clk_i)
	begin
		wr_hist   <= {wr_hist[1:0], issue_wr};
		halt_hist <= {halt_hist[1:0], halt_issued};
	end

	task automatic refresh_head();
		head_ok = (exp_q.size() != 0);
		if (head_ok)
		begin
			head = exp_q[0];
		end
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
		errors++;
	endtask

	task automatic report_error(input string what);
		$display("ERROR in %s: %s", test_name, what);
		errors++;
	endtask

	// The assertions below sample the head before this pop takes effect.
	always @(posedge clk_i)
	begin
		if (arst_n_i && wb_valid_o && (exp_q.size() != 0))
		begin
			void'(exp_q.pop_front());
			refresh_head();
		end
	end

	a_quiet_in_reset : assert property (
		@(posedge clk_i) !arst_n_i |-> (!wb_valid_o && !halt_o)
	) else report_error("an output is active while reset is asserted");

	a_wb_timing : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		wb_valid_o == wr_hist[2]
	) else report_mismatch("wb_valid", {31'd0, $sampled(wr_hist[2])},
		{31'd0, $sampled(wb_valid_o)});

	a_wb_expected : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		wb_valid_o |-> head_ok
	) else report_error("writeback pulse with no instruction outstanding");

	a_wb_addr : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		(wb_valid_o && head_ok) |-> (wb_addr_o == head.addr)
	) else report_mismatch("wb_addr", {28'd0, $sampled(head.addr)}, {28'd0, $sampled(wb_addr_o)});

	a_wb_data : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		(wb_valid_o && head_ok) |-> (wb_data_o == head.data)
	) else report_mismatch("wb_data", $sampled(head.data), $sampled(wb_data_o));

	a_halt : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		halt_o == halt_hist[2]
	) else report_mismatch("halt", {31'd0, $sampled(halt_hist[2])},
		{31'd0, $sampled(halt_o)});

	task automatic step();
		@(posedge clk_i);
		#1;
	endtask

	task automatic idle(input int cycles);
		logic [31:0] r;
		for (int i = 0; i < cycles; i++)
		begin
			r = $random(seed);
			ins_valid_i = 1'b0;
			ins_i = r;
			step();
		end
	endtask

	task automatic issue(input logic [3:0] opc, input logic [3:0] rd, input logic [3:0] ra,
		input logic [3:0] rb, input logic [15:0] imm);
		logic [31:0] imm_ext;
		wb_exp_t     e;
		imm_ext = {{16{imm[15]}}, imm};
		ins_i.opcode = opc;
		ins_i.rd = rd;
		ins_i.ra = ra;
		ins_i.rb = rb;
		ins_i.imm = imm;
		ins_valid_i = 1'b1;
		if (!halt_issued)
		begin
			if (is_writing(opc))
			begin
				e.addr = rd;
				e.data = model_alu(opc, model_regs[ra], model_regs[rb], imm_ext);
				model_regs[rd] = e.data;
				exp_q.push_back(e);
				refresh_head();
			end
			if (opc == cpu_pkg::HALT)
			begin
				halt_issued = 1'b1;
			end
		end
		step();
		ins_valid_i = 1'b0;
	endtask

	task automatic issue_random(input logic [3:0] opc);
		logic [31:0] r;
		r = $random(seed);
		issue(opc, r[3:0], r[7:4], r[11:8], r[31:16]);
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while ((exp_q.size() != 0) && (n < max_cycles))
		begin
			step();
			n++;
		end
		if (exp_q.size() != 0)
		begin
			report_error("timed out waiting for outstanding writebacks");
		end
	endtask

	task automatic wait_halt(input int max_cycles);
		int n;
		n = 0;
		while (!halt_o && (n < max_cycles))
		begin
			step();
			n++;
		end
		if (!halt_o)
		begin
			report_error("timed out waiting for halt_o");
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		if (errors == errors_at_start)
		begin
			$display("test %s: ok", test_name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
			tests_failed++;
		end
	endtask

	initial
	begin
		logic [31:0] r;
		logic [3:0]  opc;
		logic [3:0]  rd;
		seed = 32'h51a76c28;
		arst_n_i = 1'b0;
		ins_valid_i = 1'b0;
		ins_i = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		halt_issued = 1'b0;
		wr_hist = '0;
		halt_hist = '0;
		head = '0;
		head_ok = 1'b0;
		for (int i = 0; i < `CPU_NREGS; i++)
		begin
			model_regs[i] = 32'd0;
		end

		begin_test("reset");
		repeat (10) step();
		arst_n_i = 1'b1;
		idle(8);
		end_test();

		begin_test("arithmetic");
		for (int i = 0; i < `CPU_NREGS; i++)
		begin
			r = $random(seed);
			issue(cpu_pkg::LDI, 4'(i), 4'd0, 4'd0, r[15:0]);
			wait_drain(10);
		end
		for (int k = 1; k <= 7; k++)
		begin
			for (int j = 0; j < 4; j++)
			begin
				issue_random(4'(k));
				wait_drain(10);
			end
		end
		end_test();

		// Each word reads the register written d words earlier.
		begin_test("forwarding");
		for (int d = 1; d <= 3; d++)
		begin
			for (int i = 0; i < 12; i++)
			begin
				r = $random(seed);
				opc = {1'b0, r[2:0]} + 4'd1;
				if (opc == cpu_pkg::LDI)
				begin
					opc = cpu_pkg::ADDI;
				end
				rd = 4'(1 + (i % d));
				issue(opc, rd, rd, r[11:8], r[31:16]);
			end
			wait_drain(20);
		end
		end_test();

		begin_test("bubbles");
		for (int i = 0; i < 60; i++)
		begin
			r = $random(seed);
			opc = r[3:0];
			if (opc == cpu_pkg::HALT)
			begin
				opc = cpu_pkg::NOP;
			end
			issue_random(opc);
			idle(int'(r[5:4]) % 3);
		end
		wait_drain(20);
		end_test();

		begin_test("random");
		for (int i = 0; i < 200; i++)
		begin
			r = $random(seed);
			issue_random({1'b0, r[2:0]} + 4'd1);
			if (r[4])
			begin
				idle(int'(r[6:5]));
			end
		end
		wait_drain(20);
		end_test();

		begin_test("halt");
		for (int i = 0; i < 3; i++)
		begin
			issue_random(cpu_pkg::ADD);
		end
		issue(cpu_pkg::HALT, 4'd0, 4'd0, 4'd0, 16'd0);
		for (int i = 0; i < 5; i++)
		begin
			issue_random(cpu_pkg::LDI);
		end
		wait_halt(20);
		wait_drain(20);
		idle(10);
		end_test();

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if ((errors == 0) && (tests_failed == 0))
		begin
			$display("STATUS: PASS");
		end
		else
		begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
cpu_pkg.sv
cpu_regfile.sv
cpu_decode.sv
cpu_execute.sv
cpu_result.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_cpu
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := STATUS: FAIL
PASS_MSG  := STATUS: PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) cpu_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
